//--- dcache_pkg.sv
// **********************************************************************
// data cache package
// geometry, address field widths and controller states shared by the
// cache blocks
// **********************************************************************

`default_nettype none

package dcache_pkg;

	typedef logic [31:0] word_t;

	localparam int WAYS            = 2;
	localparam int SETS            = 8;
	localparam int WORDS_PER_BLOCK = 2;

	// address is {tag, index, word, byte}
	localparam int OFFSET_W = $clog2(WORDS_PER_BLOCK); // word select, bit 2
	localparam int INDEX_W  = $clog2(SETS);            // bits 5..3
	localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

	localparam int FRAMES = WAYS * SETS; // one frame per way and set

	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [$clog2(FRAMES):0] frame_t; // one extra bit to reach FRAMES

	typedef enum logic [3:0] {
		idle,
		wb_word0,
		wb_word1,
		fill_word0,
		fill_word1,
		flush_check,
		flush_word0,
		flush_word1,
		flushed_hold
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- dcache_tag_array.sv
// **********************************************************************
// data cache tag array
// valid, dirty and tag bits per way and set plus one LRU bit per set,
// with the hit/victim lookup and the flush frame view
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array
	import dcache_pkg::*;
(
	input  logic   CLK,
	input  logic   nRST,
	input  word_t  lookup_addr,
	input  frame_t flush_frame,
	input  logic   set_lru,
	input  logic   lru_way,
	input  logic   fill_en,
	input  logic   fill_way,
	input  tag_t   fill_tag,
	input  logic   dirty_en,
	input  logic   dirty_way,
	input  logic   dirty_val,
	input  logic   clear_en,
	output logic   hit,
	output logic   hit_way,
	output logic   victim_way,
	output logic   victim_dirty,
	output tag_t   victim_tag,
	output logic   frame_valid,
	output logic   frame_dirty,
	output tag_t   frame_tag
);

	logic [WAYS-1:0][SETS-1:0] valid;
	logic [WAYS-1:0][SETS-1:0] dirty;
	logic [SETS-1:0]           lru;   // way to evict next
	tag_t                      tags [WAYS][SETS];

	index_t          lk_index;
	tag_t            lk_tag;
	logic [WAYS-1:0] way_hit;
	index_t          fr_index;
	logic            fr_way;

	assign lk_index = lookup_addr[OFFSET_W+2 +: INDEX_W];
	assign lk_tag   = lookup_addr[31 -: TAG_W];

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid[w][lk_index] && (tags[w][lk_index] == lk_tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];

	// empty way first, else lru
	assign victim_way = !valid[0][lk_index] ? 1'b0 :
	                    !valid[1][lk_index] ? 1'b1 : lru[lk_index];
	assign victim_dirty = dirty[victim_way][lk_index];
	assign victim_tag   = tags[victim_way][lk_index];

	// frame = {set, way}
	assign fr_way      = flush_frame[0];
	assign fr_index    = flush_frame[INDEX_W:1];
	assign frame_valid = valid[fr_way][fr_index];
	assign frame_dirty = dirty[fr_way][fr_index];
	assign frame_tag   = tags[fr_way][fr_index];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end else begin
			if (set_lru) begin
				lru[lk_index] <= lru_way;
			end
			if (fill_en) begin
				valid[fill_way][lk_index] <= 1'b1; // block arrives clean
				dirty[fill_way][lk_index] <= 1'b0;
			end
			if (dirty_en) begin
				dirty[dirty_way][lk_index] <= dirty_val;
			end
			if (clear_en) begin
				valid[fr_way][fr_index] <= 1'b0;
				dirty[fr_way][fr_index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fill_en) begin
			tags[fill_way][lk_index] <= fill_tag;
		end
	end

	// a fill must never duplicate a block already held in the other way
	a_single_hit: assert property (@(posedge CLK) disable iff (!nRST)
		!(&way_hit));

endmodule

`default_nettype wire

//--- dcache_data_array.sv
// **********************************************************************
// data cache data array
// one word per way, set and block offset; one write port, a core read
// port for both ways and a secondary read port
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_data_array
	import dcache_pkg::*;
(
	input  logic   CLK,
	input  logic   nRST,
	input  word_t  core_addr,
	input  logic   wr_en,
	input  logic   wr_way,
	input  index_t wr_index,
	input  logic   wr_word,
	input  word_t  wr_data,
	input  logic   rd_way,
	input  index_t rd_index,
	input  logic   rd_word,
	output word_t  core_word_0,
	output word_t  core_word_1,
	output word_t  rd_data
);

	word_t mem [WAYS][SETS][WORDS_PER_BLOCK];

	index_t              core_index;
	logic [OFFSET_W-1:0] core_sel;

	assign core_index = core_addr[OFFSET_W+2 +: INDEX_W];
	assign core_sel   = core_addr[2 +: OFFSET_W];

	// both ways, top level picks by hit_way
	assign core_word_0 = mem[0][core_index][core_sel];
	assign core_word_1 = mem[1][core_index][core_sel];

	assign rd_data = mem[rd_way][rd_index][rd_word]; // write-back / flush source

	always_ff @(posedge CLK) begin
		if (wr_en && nRST) begin // no writes while reset is held
			mem[wr_way][wr_index][wr_word] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- dcache_ctrl.sv
// **********************************************************************
// data cache controller
// FSM for hits, victim write-back, block fill and the halt flush walk;
// drives the memory port and the array write controls
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic   CLK,
	input  logic   nRST,
	input  logic   dmem_ren,
	input  logic   dmem_wen,
	input  word_t  dmem_addr,
	input  word_t  dmem_store,
	input  logic   halt,
	input  logic   hit,
	input  logic   hit_way,
	input  logic   victim_way,
	input  logic   victim_dirty,
	input  tag_t   victim_tag,
	input  logic   frame_valid,
	input  logic   frame_dirty,
	input  tag_t   frame_tag,
	input  word_t  rd_data,
	input  word_t  mem_load,
	input  logic   mem_wait,
	output logic   dhit,
	output logic   flushed,
	output logic   mem_ren,
	output logic   mem_wen,
	output word_t  mem_addr,
	output word_t  mem_store,
	output logic   set_lru,
	output logic   lru_way,
	output logic   fill_en,
	output logic   fill_way,
	output tag_t   fill_tag,
	output logic   dirty_en,
	output logic   dirty_way,
	output logic   dirty_val,
	output logic   clear_en,
	output frame_t flush_frame,
	output logic   wr_en,
	output logic   wr_way,
	output index_t wr_index,
	output logic   wr_word,
	output word_t  wr_data,
	output logic   rd_way,
	output index_t rd_index,
	output logic   rd_word
);

	ctrl_state_t state, next_state;
	frame_t      count, next_count; // flush frame walk

	index_t index;
	tag_t   req_tag;
	logic   req;
	logic   mem_done;

	assign index    = dmem_addr[OFFSET_W+2 +: INDEX_W];
	assign req_tag  = dmem_addr[31 -: TAG_W];
	assign req      = dmem_ren | dmem_wen;
	assign mem_done = !mem_wait;

	assign flush_frame = count;
	assign flushed     = (state == flushed_hold);
	assign mem_store   = rd_data;   // only meaningful with mem_wen
	assign fill_tag    = req_tag;
	assign fill_way    = victim_way;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= idle;
			count <= '0;
		end else begin
			state <= next_state;
			count <= next_count;
		end
	end

	always_comb begin
		next_state = state;
		next_count = count;
		dhit       = 1'b0;
		mem_ren    = 1'b0;
		mem_wen    = 1'b0;
		mem_addr   = dmem_addr;
		set_lru    = 1'b0;
		lru_way    = ~hit_way;  // other way becomes lru
		fill_en    = 1'b0;
		dirty_en   = 1'b0;
		dirty_way  = victim_way;
		dirty_val  = 1'b0;
		clear_en   = 1'b0;
		wr_en      = 1'b0;
		wr_way     = victim_way;
		wr_index   = index;
		wr_word    = 1'b0;
		wr_data    = mem_load;
		rd_way     = victim_way;
		rd_index   = index;
		rd_word    = 1'b0;

		case (state)
			idle: begin
				if (req && hit) begin
					dhit    = 1'b1;
					set_lru = 1'b1;
					if (dmem_wen) begin
						wr_en     = 1'b1;
						wr_way    = hit_way;
						wr_word   = dmem_addr[2];
						wr_data   = dmem_store;
						dirty_en  = 1'b1;
						dirty_way = hit_way;
						dirty_val = 1'b1;
					end
				end else if (req) begin
					next_state = victim_dirty ? wb_word0 : fill_word0;
				end else if (halt) begin
					next_count = '0;
					next_state = flush_check;
				end
			end

			// victim block out to memory
			wb_word0, wb_word1: begin
				mem_wen  = 1'b1;
				rd_word  = (state == wb_word1);
				mem_addr = {victim_tag, index, rd_word, 2'b00};
				if (mem_done) begin
					if (state == wb_word0) begin
						next_state = wb_word1;
					end else begin
						dirty_en   = 1'b1; // victim now clean
						next_state = fill_word0;
					end
				end
			end

			fill_word0, fill_word1: begin
				mem_ren  = 1'b1;
				wr_word  = (state == fill_word1);
				mem_addr = {req_tag, index, wr_word, 2'b00};
				if (mem_done) begin
					wr_en = 1'b1;
					if (state == fill_word0) begin
						next_state = fill_word1;
					end else begin
						fill_en    = 1'b1; // tag and valid with last word
						next_state = idle;
					end
				end
			end

			flush_check: begin
				if (count == frame_t'(FRAMES)) begin
					next_state = flushed_hold;
				end else if (frame_valid && frame_dirty) begin
					next_state = flush_word0;
				end else begin
					clear_en   = 1'b1;
					next_count = count + 1'b1;
				end
			end

			flush_word0, flush_word1: begin
				mem_wen  = 1'b1;
				rd_way   = count[0];
				rd_index = count[INDEX_W:1];
				rd_word  = (state == flush_word1);
				mem_addr = {frame_tag, count[INDEX_W:1], rd_word, 2'b00};
				if (mem_done) begin
					if (state == flush_word0) begin
						next_state = flush_word1;
					end else begin
						clear_en   = 1'b1;
						next_count = count + 1'b1;
						next_state = flush_check;
					end
				end
			end

			flushed_hold: begin
				next_state = flushed_hold; // until reset
			end

			default: begin
				next_state = idle;
			end
		endcase
	end

	a_mem_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_ren && mem_wen));

	// once flushed, stays flushed until reset
	a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed);

endmodule

`default_nettype wire

//--- dcache.sv
// **********************************************************************
// data cache top
// 2-way write-back cache; wires the controller to the tag and data
// arrays and selects the load word by hit way
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module dcache
	import dcache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	input  logic  dmem_ren,
	input  logic  dmem_wen,
	input  word_t dmem_addr,
	input  word_t dmem_store,
	input  logic  halt,
	output word_t dmem_load,
	output logic  dhit,
	output logic  flushed,
	output logic  mem_ren,
	output logic  mem_wen,
	output word_t mem_addr,
	output word_t mem_store,
	input  word_t mem_load,
	input  logic  mem_wait
);

	logic   hit, hit_way, victim_way, victim_dirty;
	tag_t   victim_tag, frame_tag, fill_tag;
	logic   frame_valid, frame_dirty;
	frame_t flush_frame;
	logic   set_lru, lru_way, fill_en, fill_way;
	logic   dirty_en, dirty_way, dirty_val, clear_en;
	logic   wr_en, wr_way, wr_word, rd_way, rd_word;
	index_t wr_index, rd_index;
	word_t  wr_data, rd_data;
	word_t  core_word_0, core_word_1;

	assign dmem_load = hit_way ? core_word_1 : core_word_0;

	dcache_ctrl u_ctrl (
		.CLK, .nRST,
		.dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.frame_valid, .frame_dirty, .frame_tag,
		.rd_data, .mem_load, .mem_wait,
		.dhit, .flushed, .mem_ren, .mem_wen, .mem_addr, .mem_store,
		.set_lru, .lru_way, .fill_en, .fill_way, .fill_tag,
		.dirty_en, .dirty_way, .dirty_val, .clear_en, .flush_frame,
		.wr_en, .wr_way, .wr_index, .wr_word, .wr_data,
		.rd_way, .rd_index, .rd_word
	);

	dcache_tag_array u_tags (
		.CLK, .nRST,
		.lookup_addr(dmem_addr),
		.flush_frame, .set_lru, .lru_way,
		.fill_en, .fill_way, .fill_tag,
		.dirty_en, .dirty_way, .dirty_val, .clear_en,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.frame_valid, .frame_dirty, .frame_tag
	);

	dcache_data_array u_data (
		.CLK, .nRST,
		.core_addr(dmem_addr),
		.wr_en, .wr_way, .wr_index, .wr_word, .wr_data,
		.rd_way, .rd_index, .rd_word,
		.core_word_0, .core_word_1, .rd_data
	);

endmodule

`default_nettype wire

//--- tb_mem_model.sv
// **********************************************************************
// testbench memory model
// word-addressed storage behind the cache memory port, random wait
// states per word and a backdoor read port for end-of-test checking
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
	import dcache_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,
	input  logic       mem_ren,
	input  logic       mem_wen,
	input  word_t      mem_addr,
	input  word_t      mem_store,
	output word_t      mem_load,
	output logic       mem_wait,
	input  logic [7:0] peek_addr,
	output word_t      peek_data,
	output logic       bad_addr
);

	localparam int MEM_WORDS = 256; // byte addresses 0x000..0x3ff

	word_t      mem [MEM_WORDS];
	logic [1:0] wait_left; // stall cycles left for current word
	logic       active;
	logic [7:0] widx;

	assign active    = mem_ren | mem_wen;
	assign widx      = mem_addr[9:2];
	assign mem_wait  = active && (wait_left != 2'd0);
	assign mem_load  = mem[widx];
	assign peek_data = mem[peek_addr];

	// each word holds its own word address xor a marker
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[8'(i)] = word_t'(i) ^ 32'hA5A5_0000;
		end
	end

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			wait_left <= 2'd0;
			bad_addr  <= 1'b0;
		end else if (active) begin
			if (mem_addr[31:10] != '0 || mem_addr[1:0] != 2'b00) begin
				bad_addr <= 1'b1; // outside the modeled range
			end
			if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				wait_left <= 2'($urandom_range(3, 0)); // stalls for next word
			end
		end
	end

	always @(posedge CLK) begin
		if (nRST && mem_wen && !mem_wait) begin
			mem[widx] <= mem_store;
		end
	end

endmodule

`default_nettype wire

//--- tb_dcache.sv
// **********************************************************************
// data cache testbench
// runs a table of reads, writes and a halt against the cache, checks
// loads against a shadow memory and the flushed memory image
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_dcache
	import dcache_pkg::*;
();

	localparam int          OP_READ  = 0;
	localparam int          OP_WRITE = 1;
	localparam int          OP_HALT  = 2;
	localparam int          MEM_WORDS = 256;
	localparam int unsigned SEED     = 32'h15a7_c0d5;

	typedef struct {
		int    op;
		word_t addr;
		word_t data;
		bit    mem_used; // access must reach memory, else must not
		string name;
	} entry_t;

	logic       CLK, nRST;
	logic       dmem_ren, dmem_wen, halt;
	word_t      dmem_addr, dmem_store, dmem_load;
	logic       dhit, flushed;
	logic       mem_ren, mem_wen, mem_wait;
	word_t      mem_addr, mem_store, mem_load;
	logic [7:0] peek_addr;
	word_t      peek_data;
	logic       bad_addr;

	entry_t tests [$];
	word_t  shadow [MEM_WORDS];
	int     errors, tests_run, tests_failed;
	int     cycles, cycle_limit;

	dcache dut (
		.CLK, .nRST,
		.dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
		.dmem_load, .dhit, .flushed,
		.mem_ren, .mem_wen, .mem_addr, .mem_store,
		.mem_load, .mem_wait
	);

	tb_mem_model u_mem (
		.CLK, .nRST,
		.mem_ren, .mem_wen, .mem_addr, .mem_store,
		.mem_load, .mem_wait,
		.peek_addr, .peek_data, .bad_addr
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: the DUT did not answer within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic add_test(input int op, input word_t addr, input word_t data,
	                        input bit mem_used, input string name);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = data;
		e.mem_used = mem_used;
		e.name     = name;
		tests.push_back(e);
	endtask

	task automatic finish_test(input string name, input int new_errors);
		tests_run++;
		if (new_errors == 0) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s (%0d mismatches)", name, new_errors);
		end
	endtask

	// one core access, held until dhit
	task automatic run_access(input entry_t e);
		bit traffic;
		traffic = 1'b0;
		@(posedge CLK);
		#1;
		dmem_ren   = (e.op == OP_READ);
		dmem_wen   = (e.op == OP_WRITE);
		dmem_addr  = e.addr;
		dmem_store = e.data;
		@(negedge CLK);
		while (!dhit) begin
			traffic = traffic | mem_ren | mem_wen;
			@(negedge CLK);
		end
		if (e.op == OP_WRITE) begin
			shadow[e.addr[9:2]] = e.data;
		end else begin
			check(e.name, shadow[e.addr[9:2]], dmem_load);
		end
		check({e.name, " memory traffic"}, word_t'(e.mem_used), word_t'(traffic));
	endtask

	// halt, wait for flushed, then compare the whole memory image
	task automatic run_flush(input entry_t e);
		@(posedge CLK);
		#1;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		halt     = 1'b1;
		@(negedge CLK);
		while (!flushed) begin
			@(negedge CLK);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			peek_addr = 8'(i);
			#1;
			check($sformatf("%s word %0d", e.name, i), shadow[8'(i)], peek_data);
		end
		check({e.name, " flushed held"}, 32'd1, word_t'(flushed));
	endtask

	initial begin
		int errs_before;
		void'($urandom(SEED));
		CLK        = 1'b0;
		nRST       = 1'b0;
		dmem_ren   = 1'b0;
		dmem_wen   = 1'b0;
		dmem_addr  = '0;
		dmem_store = '0;
		halt       = 1'b0;
		peek_addr  = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cycles       = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[8'(i)] = word_t'(i) ^ 32'hA5A5_0000;
		end

		// index 1 holds tags 0, 1 and 2 in turn
		add_test(OP_READ,  32'h0000_0008, 32'h0, 1'b1, "read miss word0");
		add_test(OP_READ,  32'h0000_000C, 32'h0, 1'b0, "read hit word1");
		add_test(OP_WRITE, 32'h0000_000C, 32'h1111_2222, 1'b0, "write hit word1");
		add_test(OP_READ,  32'h0000_000C, 32'h0, 1'b0, "read back word1");
		add_test(OP_WRITE, 32'h0000_0008, 32'hDEAD_BEEF, 1'b0, "write hit word0");
		add_test(OP_READ,  32'h0000_0048, 32'h0, 1'b1, "conflict fill tag1");
		add_test(OP_READ,  32'h0000_0088, 32'h0, 1'b1, "conflict evict tag0");
		add_test(OP_READ,  32'h0000_0008, 32'h0, 1'b1, "refetch tag0 word0");
		add_test(OP_READ,  32'h0000_000C, 32'h0, 1'b0, "refetch tag0 word1");
		add_test(OP_WRITE, 32'h0000_0020, 32'h0BAD_F00D, 1'b1, "write miss index4");
		add_test(OP_WRITE, 32'h0000_003C, 32'h7777_8888, 1'b1, "write miss index7");
		add_test(OP_READ,  32'h0000_004C, 32'h0, 1'b1, "reread tag1 word1");
		add_test(OP_HALT,  32'h0000_0000, 32'h0, 1'b0, "halt flush");

		// up to 4 word accesses of 5 cycles per entry, 32 flush words
		cycle_limit = tests.size() * 4 * 5 + 32 * 5 + 200;

		repeat (8) @(posedge CLK);
		#1;
		nRST = 1'b1;

		@(negedge CLK);
		errs_before = errors;
		check("reset dhit", 32'd0, word_t'(dhit));
		check("reset mem_ren", 32'd0, word_t'(mem_ren));
		check("reset mem_wen", 32'd0, word_t'(mem_wen));
		check("reset flushed", 32'd0, word_t'(flushed));
		finish_test("reset state", errors - errs_before);

		foreach (tests[t]) begin
			errs_before = errors;
			if (tests[t].op == OP_HALT) begin
				run_flush(tests[t]);
			end else begin
				run_access(tests[t]);
			end
			finish_test(tests[t].name, errors - errs_before);
		end

		errs_before = errors;
		check("memory address range", 32'd0, word_t'(bad_addr));
		finish_test("memory address range", errors - errs_before);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache.sv
tb_mem_model.sv
tb_dcache.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
